/* fetch_asserts.sv */
// concurrent checks on the fetch unit, active only with assertions enabled; fail_cnt sums failures
`timescale 1ns/1ps

module fetch_asserts (
	input logic                  clk,
	input logic                  rst,
	input fetch_pkg::ar_chan_t   ar,
	input logic                  ar_valid,
	input logic                  ar_ready,
	input logic                  r_ready,
	input fetch_pkg::fetch_out_t fetch_out,
	input logic                  fetch_valid,
	input logic                  idu_allowin
);

	int ar_fails = 0;
	int hold_fails = 0;
	int flight_fails = 0;
	int reset_fails = 0;
	int fail_cnt;

	assign fail_cnt = ar_fails + hold_fails + flight_fails + reset_fails;

	// address held until the rom takes it
	ar_stable: assert property (@(posedge clk) disable iff (rst)
		(ar_valid && !ar_ready) |=> (ar_valid && $stable(ar)))
	else begin
		$error("ar changed or ar_valid dropped before ar_ready");
		ar_fails++;
	end

	// item for decode frozen under back-pressure
	out_stable: assert property (@(posedge clk) disable iff (rst)
		(fetch_valid && !idu_allowin) |=> (fetch_valid && $stable(fetch_out)))
	else begin
		$error("fetch_out changed or fetch_valid dropped while held");
		hold_fails++;
	end

	// address phase, data phase and held item are exclusive
	one_in_flight: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ar_valid, r_ready, fetch_valid}))
	else begin
		$error("more than one fetch in flight");
		flight_fails++;
	end

	reset_quiet: assert property (@(posedge clk)
		rst |=> (!ar_valid && !r_ready && !fetch_valid))
	else begin
		$error("handshake outputs not low after reset");
		reset_fails++;
	end

endmodule

bind ifu fetch_asserts u_fetch_asserts (
	.clk         (clk),
	.rst         (rst),
	.ar          (ar),
	.ar_valid    (ar_valid),
	.ar_ready    (ar_ready),
	.r_ready     (r_ready),
	.fetch_out   (fetch_out),
	.fetch_valid (fetch_valid),
	.idu_allowin (idu_allowin)
);

/* fetch_pkg.sv */
// shared fetch types; rom base is RESET_PC, word aligned pcs only, one read in flight
package fetch_pkg;

	// address and instruction width
	localparam int XLEN = 32;

	// memory map of the instruction rom
	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;
	localparam int ISRAM_WORDS = 64;
	localparam int ISRAM_AW = $clog2(ISRAM_WORDS);
	localparam string ISRAM_FILE = "prog.hex";

	// read response, same coding as an axi rresp
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// fetch unit read fsm
	typedef enum logic [1:0] {
		IDLE,
		WAIT_ARREADY,
		WAIT_RVALID,
		HOLD
	} fetch_state_e;

	// read address channel payload
	typedef struct packed {
		logic [XLEN-1:0] addr;
	} ar_chan_t;

	// read data channel payload
	typedef struct packed {
		logic [XLEN-1:0] data;
		resp_e           resp;
	} r_chan_t;

	// redirect from execute
	typedef struct packed {
		logic [XLEN-1:0] target;
	} redirect_t;

	// item handed to decode
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
		logic            err;
	} fetch_out_t;

endpackage

/* fetch_top.sv */
// fetch front end; decode and execute sit outside, redirect is a one cycle pulse
`timescale 1ns/1ps

module fetch_top (
	input  logic                  clk,
	input  logic                  rst,
	input  fetch_pkg::redirect_t  redirect,
	input  logic                  redirect_valid,
	output fetch_pkg::fetch_out_t fetch_out,
	output logic                  fetch_valid,
	input  logic                  idu_allowin
);
	import fetch_pkg::*;

	// memory channels between fetch unit and rom
	ar_chan_t ar;
	logic     ar_valid;
	logic     ar_ready;
	r_chan_t  r;
	logic     r_valid;
	logic     r_ready;

	ifu u_ifu (
		.clk            (clk),
		.rst            (rst),
		.redirect       (redirect),
		.redirect_valid (redirect_valid),
		.ar             (ar),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.r              (r),
		.r_valid        (r_valid),
		.r_ready        (r_ready),
		.fetch_out      (fetch_out),
		.fetch_valid    (fetch_valid),
		.idu_allowin    (idu_allowin)
	);

	isram u_isram (
		.clk      (clk),
		.rst      (rst),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

endmodule

/* ifu.sv */
// one fetch in flight; a redirect never drops a held item, it steers the fetch after it
`timescale 1ns/1ps

module ifu (
	input  logic                  clk,
	input  logic                  rst,
	// redirect from execute
	input  fetch_pkg::redirect_t  redirect,
	input  logic                  redirect_valid,
	// read address channel
	output fetch_pkg::ar_chan_t   ar,
	output logic                  ar_valid,
	input  logic                  ar_ready,
	// read data channel
	input  fetch_pkg::r_chan_t    r,
	input  logic                  r_valid,
	output logic                  r_ready,
	// decode channel
	output fetch_pkg::fetch_out_t fetch_out,
	output logic                  fetch_valid,
	input  logic                  idu_allowin
);
	import fetch_pkg::*;

	fetch_state_e state;
	fetch_state_e state_nxt;

	// next sequential fetch address
	logic [XLEN-1:0] pc;
	logic            redir_pend;
	logic [XLEN-1:0] redir_tgt;
	logic [XLEN-1:0] fetch_pc;

	logic ar_done;
	logic r_done;
	logic accept;
	logic start;

	assign ar_done = ar_valid && ar_ready;
	assign r_done = r_valid && r_ready;
	assign accept = fetch_valid && idu_allowin;

	// a fetch starts out of reset or on the cycle decode takes the held item
	assign start = (state == IDLE) || (state == HOLD && accept);

	// newest redirect wins, a pulse on the start cycle is used right away
	always_comb begin
		if (redirect_valid) begin
			fetch_pc = redirect.target;
		end else if (redir_pend) begin
			fetch_pc = redir_tgt;
		end else begin
			fetch_pc = pc;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: state_nxt = WAIT_ARREADY;
			WAIT_ARREADY: begin
				if (ar_done) begin
					state_nxt = WAIT_RVALID;
				end
			end
			WAIT_RVALID: begin
				if (r_done) begin
					state_nxt = HOLD;
				end
			end
			HOLD: begin
				// go straight to the next address phase, no idle bubble
				if (accept) begin
					state_nxt = WAIT_ARREADY;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// channel handshake flags
	always_ff @(posedge clk) begin
		if (rst) begin
			ar_valid <= 1'b0;
			r_ready <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			if (start) begin
				ar_valid <= 1'b1;
			end else if (ar_done) begin
				ar_valid <= 1'b0;
			end
			if (ar_done) begin
				r_ready <= 1'b1;
			end else if (r_done) begin
				r_ready <= 1'b0;
			end
			if (r_done) begin
				fetch_valid <= 1'b1;
			end else if (accept) begin
				fetch_valid <= 1'b0;
			end
		end
	end

	// pc and pending redirect
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			redir_pend <= 1'b0;
		end else if (start) begin
			pc <= fetch_pc + XLEN'(4);
			redir_pend <= 1'b0;
		end else if (redirect_valid) begin
			redir_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_valid) begin
			redir_tgt <= redirect.target;
		end
	end

	// address stays put from start until the next start
	always_ff @(posedge clk) begin
		if (start) begin
			ar.addr <= fetch_pc;
		end
	end

	// output register, held until decode allows it in
	always_ff @(posedge clk) begin
		if (r_done) begin
			fetch_out.pc <= ar.addr;
			fetch_out.inst <= r.data;
			fetch_out.err <= (r.resp == RESP_SLVERR);
		end
	end

endmodule

/* isram.sv */
// behavioral rom, one read at a time; ar_ready 0-3 waits, r_valid 1-4 cycles after the address
`timescale 1ns/1ps

module isram (
	input  logic                clk,
	input  logic                rst,
	// read address channel
	input  fetch_pkg::ar_chan_t ar,
	input  logic                ar_valid,
	output logic                ar_ready,
	// read data channel
	output fetch_pkg::r_chan_t  r,
	output logic                r_valid,
	input  logic                r_ready
);
	import fetch_pkg::*;

	logic [XLEN-1:0] mem [ISRAM_WORDS];

	// wait state source, x^8+x^6+x^5+x^4+1
	logic [7:0] lfsr;
	logic       lfsr_fb;

	logic [1:0] ar_cnt;
	logic [1:0] r_cnt;
	// address taken, response not yet delivered
	logic       pend;

	logic [XLEN-1:0]     addr_q;
	logic [XLEN-1:0]     off;
	logic                hit;
	logic [ISRAM_AW-1:0] idx;

	logic ar_done;
	logic r_done;

	initial begin
		$readmemh(ISRAM_FILE, mem);
	end

	assign ar_done = ar_valid && ar_ready;
	assign r_done = r_valid && r_ready;

	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= 8'ha5;
		end else begin
			lfsr <= {lfsr[6:0], lfsr_fb};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ar_ready <= 1'b0;
			ar_cnt <= '0;
			r_valid <= 1'b0;
			r_cnt <= '0;
			pend <= 1'b0;
		end else begin
			if (ar_done) begin
				// draw both delays for this access
				ar_ready <= 1'b0;
				ar_cnt <= lfsr[1:0];
				pend <= 1'b1;
				r_cnt <= lfsr[5:4];
				r_valid <= (lfsr[5:4] == 2'd0);
			end else if (ar_valid && !ar_ready && !pend) begin
				if (ar_cnt == 2'd0) begin
					ar_ready <= 1'b1;
				end else begin
					ar_cnt <= ar_cnt - 2'd1;
				end
			end
			if (pend && !r_valid) begin
				if (r_cnt == 2'd1) begin
					r_valid <= 1'b1;
				end
				r_cnt <= r_cnt - 2'd1;
			end
			if (r_done) begin
				r_valid <= 1'b0;
				pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_done) begin
			addr_q <= ar.addr;
		end
	end

	// addresses below the base wrap to a large offset and miss too
	assign off = addr_q - RESET_PC;
	assign hit = off < XLEN'(ISRAM_WORDS * 4);
	assign idx = off[ISRAM_AW+1:2];

	// rom contents never change, so r holds while r_valid waits
	assign r.data = hit ? mem[idx] : '0;
	assign r.resp = hit ? RESP_OKAY : RESP_SLVERR;

endmodule

/* prog.hex */
// one 32-bit instruction word per line (addi x1, x1, n with n the word index), word 0 at RESET_PC
00008093
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093
02108093
02208093
02308093
02408093
02508093
02608093
02708093
02808093
02908093
02a08093
02b08093
02c08093
02d08093
02e08093
02f08093
03008093
03108093
03208093
03308093
03408093
03508093
03608093
03708093
03808093
03908093
03a08093
03b08093
03c08093
03d08093
03e08093
03f08093

/* run.sh */
#!/bin/sh
# build the fetch testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_fetch_top -o Vtb_fetch_top
output=$(./obj_dir/Vtb_fetch_top +verilator+error+limit+100 || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

/* tb_fetch_top.sv */
// plays decode and execute around fetch_top; run from the project root so prog.hex is found
`timescale 1ns/1ps

module tb_fetch_top;
	import fetch_pkg::*;

	localparam int SEQ_ITEMS = 21;
	localparam int RAND_ITEMS = 30;
	localparam int REDIR_ITEMS = 5;
	localparam int OOR_ITEMS = 4;
	localparam int WRAP_ITEMS = 7;
	localparam int TOTAL_ITEMS = SEQ_ITEMS + RAND_ITEMS + REDIR_ITEMS + 2 * OOR_ITEMS + WRAP_ITEMS;
	localparam int MAX_CYCLES = 8 * TOTAL_ITEMS + 400;

	logic       clk;
	logic       rst;
	redirect_t  redirect;
	logic       redirect_valid;
	fetch_out_t fetch_out;
	logic       fetch_valid;
	logic       idu_allowin;

	logic [XLEN-1:0] ref_mem [ISRAM_WORDS];
	logic [31:0]     lcg_state;

	// model state of the compare process
	logic [XLEN-1:0] exp_pc;
	logic            redir_seen;
	logic [XLEN-1:0] redir_seen_tgt;
	logic            held;
	fetch_out_t      held_item;

	int accept_cnt = 0;
	int err_cnt = 0;
	int cycle_cnt = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int assert_fails;

	assign assert_fails = i_fetch_top.u_ifu.u_fetch_asserts.fail_cnt;

	fetch_top i_fetch_top (
		.clk            (clk),
		.rst            (rst),
		.redirect       (redirect),
		.redirect_valid (redirect_valid),
		.fetch_out      (fetch_out),
		.fetch_valid    (fetch_valid),
		.idu_allowin    (idu_allowin)
	);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// expected item for a pc, rom window RESET_PC up to the last word
	function automatic fetch_out_t expected_item(input logic [XLEN-1:0] pc);
		fetch_out_t          item;
		logic [XLEN-1:0]     last;
		logic [ISRAM_AW-1:0] word;
		last = RESET_PC + XLEN'(4 * ISRAM_WORDS - 4);
		word = ISRAM_AW'((pc - RESET_PC) >> 2);
		item.pc = pc;
		if (pc >= RESET_PC && pc <= last) begin
			item.inst = ref_mem[word];
			item.err = 1'b0;
		end else begin
			item.inst = '0;
			item.err = 1'b1;
		end
		return item;
	endfunction

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout after %0d cycles with %0d items accepted", cycle_cnt, accept_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin : compare
		fetch_out_t exp_item;
		if (rst) begin
			exp_pc = RESET_PC;
			redir_seen = 1'b0;
			held = 1'b0;
		end else begin
			// newest redirect steers the fetch after the current one
			if (redirect_valid) begin
				redir_seen = 1'b1;
				redir_seen_tgt = redirect.target;
			end
			// a held item stays offered and unchanged
			if (held) begin
				assert (fetch_valid) else begin
					$display("Fail fetch_valid held: got %h, expected %h", fetch_valid, 1'b1);
					err_cnt++;
				end
				assert (fetch_out == held_item) else begin
					$display("Fail fetch_out held: got %h, expected %h", fetch_out, held_item);
					err_cnt++;
				end
			end
			if (fetch_valid && idu_allowin) begin
				exp_item = expected_item(exp_pc);
				assert (fetch_out.pc == exp_item.pc) else begin
					$display("Fail fetch_out.pc: got %h, expected %h", fetch_out.pc, exp_item.pc);
					err_cnt++;
				end
				assert (fetch_out.inst == exp_item.inst) else begin
					$display("Fail fetch_out.inst: got %h, expected %h",
						fetch_out.inst, exp_item.inst);
					err_cnt++;
				end
				assert (fetch_out.err == exp_item.err) else begin
					$display("Fail fetch_out.err: got %h, expected %h", fetch_out.err, exp_item.err);
					err_cnt++;
				end
				exp_pc = redir_seen ? redir_seen_tgt : exp_pc + 32'd4;
				redir_seen = 1'b0;
				accept_cnt <= accept_cnt + 1;
			end
			held = fetch_valid && !idu_allowin;
			held_item = fetch_out;
		end
	end

	// wait for n more accepted items, optionally with lcg back-pressure
	task automatic take_items(input int n, input bit random_allowin);
		int target;
		target = accept_cnt + n;
		while (accept_cnt < target) begin
			@(posedge clk);
			if (random_allowin) begin
				lcg_state = lcg_next(lcg_state);
				idu_allowin <= lcg_state[16];
			end
		end
	endtask

	// stall decode, then pulse a redirect while the item sits in the output register
	task automatic redirect_when_held(input logic [XLEN-1:0] target);
		idu_allowin <= 1'b0;
		@(posedge clk);
		while (!(fetch_valid && !idu_allowin)) begin
			@(posedge clk);
		end
		redirect.target <= target;
		redirect_valid <= 1'b1;
		@(posedge clk);
		redirect_valid <= 1'b0;
		idu_allowin <= 1'b1;
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		int errs;
		errs = err_cnt + assert_fails - errs_before;
		if (errs == 0) begin
			tests_passed++;
			$display("test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errs);
		end
	endtask

	initial begin
		int base;
		$readmemh("prog.hex", ref_mem);
		lcg_state = 32'd99;
		rst <= 1'b1;
		redirect <= '0;
		redirect_valid <= 1'b0;
		idu_allowin <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		idu_allowin <= 1'b1;

		base = err_cnt + assert_fails;
		take_items(SEQ_ITEMS, 1'b0);
		report_test(1, "sequential from reset", base);

		base = err_cnt + assert_fails;
		take_items(RAND_ITEMS, 1'b1);
		report_test(2, "random back-pressure", base);

		base = err_cnt + assert_fails;
		redirect_when_held(RESET_PC + 32'h40);
		take_items(REDIR_ITEMS, 1'b0);
		report_test(3, "redirect while held", base);

		// far past the rom, then back inside
		base = err_cnt + assert_fails;
		redirect_when_held(RESET_PC + 32'h1000);
		take_items(OOR_ITEMS, 1'b0);
		redirect_when_held(RESET_PC + 32'h8);
		take_items(OOR_ITEMS, 1'b0);
		report_test(4, "out of range and back", base);

		base = err_cnt + assert_fails;
		redirect_when_held(RESET_PC + XLEN'(4 * (ISRAM_WORDS - 4)));
		take_items(WRAP_ITEMS, 1'b0);
		report_test(5, "run off the rom end", base);

		repeat (2) @(posedge clk);
		$display("tests passed %0d, failed %0d, items %0d, errors %0d",
			tests_passed, tests_failed, accept_cnt, err_cnt + assert_fails);
		if (tests_failed == 0 && err_cnt + assert_fails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
fetch_pkg.sv
ifu.sv
isram.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch_top.sv
